// File: gsu_top.f
design/gsu_pkg.sv
design/gsu_reg_if.sv
design/gsu_cache_if.sv
design/gsu_mmio_decode.sv
design/gsu_regfile.sv
design/gsu_cache_ram.sv
design/gsu_top.sv
testbench/gsu_tb.sv

// File: testbench/gsu_stim.txt
# op addr data test  (hex addr and data, decimal test number)
# W write, R read, B read with no gap, M read miss, D debug read, S status bits
R 03B 04 1
R 030 00 1
R 031 00 1
R 034 00 1
R 03E 00 1
R 03F 00 1
S 000 00 1
W 004 34 2
R 004 00 2
R 005 00 2
W 005 12 2
R 004 34 2
R 005 12 2
R 006 00 2
R 000 00 2
W 034 FF 3
R 034 FF 3
W 03A FF 3
S 000 06 3
W 03A 10 3
S 000 02 3
W 03A 08 3
S 000 04 3
W 03A 00 3
M 037 00 3
M 038 00 3
M 032 00 3
M 03A 00 3
W 031 FF 3
R 031 9F 3
W 031 00 3
W 030 FF 3
R 030 7E 3
S 000 01 3
W 030 00 3
R 030 00 3
S 000 00 3
W 100 A5 4
W 205 3C 4
W 3FF 5A 4
R 100 A5 4
R 205 3C 4
D 000 A5 4
D 105 3C 4
D 0FF 5A 4
W 030 20 5
S 000 01 5
R 030 20 5
R 03B 04 5
W 004 99 5
W 005 88 5
W 100 77 5
M 004 00 5
M 100 00 5
M 034 00 5
W 030 00 5
S 000 00 5
R 004 34 5
R 005 12 5
R 100 A5 5
R 004 34 6
B 005 12 6
B 100 A5 6
B 205 3C 6
B 03B 04 6

// File: testbench/gsu_tb.sv
`timescale 1ns/1ps

module gsu_tb;

  localparam int CLK_HALF      = 10;
  localparam int RST_CYCLES    = 16;
  localparam int CYCLES_PER_OP = 8;

  logic       CLK;
  logic       RST;
  logic       ENABLE;
  logic       RD_START;
  logic       WR_END;
  logic [9:0] ADDR;
  logic [7:0] DATA_IN;
  logic       DATA_ENABLE;
  logic [7:0] DATA_OUT;
  logic       ACTIVE;
  logic       RON;
  logic       RAN;
  logic [9:0] PGM_ADDR;
  logic [7:0] PGM_DATA;

  // Stimulus lines
  byte        op_q[$];
  logic [9:0] addr_q[$];
  logic [7:0] data_q[$];
  int         test_q[$];

  // Pending checks, ordered by due cycle
  int         due_q[$];
  byte        kind_q[$];
  logic [7:0] exp_q[$];

  int         cyc = 0;
  int         limit = 100;
  int         errors = 0;
  int         checks = 0;
  int         ntests = 0;
  int         test_err = 0;
  byte        cur_kind;
  logic [7:0] cur_exp;
  // Byte of the last successful read, held through misses
  logic [7:0] last_out = 8'h00;

  gsu_top gsu_top_i (
    .CLK         (CLK),
    .RST         (RST),
    .ENABLE      (ENABLE),
    .RD_START    (RD_START),
    .WR_END      (WR_END),
    .ADDR        (ADDR),
    .DATA_IN     (DATA_IN),
    .DATA_ENABLE (DATA_ENABLE),
    .DATA_OUT    (DATA_OUT),
    .ACTIVE      (ACTIVE),
    .RON         (RON),
    .RAN         (RAN),
    .PGM_ADDR    (PGM_ADDR),
    .PGM_DATA    (PGM_DATA)
  );

  initial begin
    CLK = 1'b0;
    forever #CLK_HALF CLK = ~CLK;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic load_stim();
    int         fd;
    int         n;
    string      line;
    byte        op;
    logic [9:0] a;
    logic [7:0] d;
    int         t;
    fd = $fopen("testbench/gsu_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/gsu_stim.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, " %c %h %h %d", op, a, d, t);
      // Comment and blank lines fall out here
      if (n == 4 && op != "#") begin
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        test_q.push_back(t);
      end
    end
    $fclose(fd);
    if (op_q.size() == 0) begin
      $display("No operations found in the stimulus file");
      errors++;
    end
  endtask

  // All strobes low, addresses kept
  task automatic drive_idle();
    ENABLE   <= 1'b0;
    RD_START <= 1'b0;
    WR_END   <= 1'b0;
  endtask

  task automatic push_check(input byte kind, input logic [7:0] exp, input int due);
    due_q.push_back(due);
    kind_q.push_back(kind);
    exp_q.push_back(exp);
  endtask

  task automatic report_value(input string name, input logic [7:0] exp,
                              input logic [7:0] got);
    $display("Fail at %0d ns: %s expected %h got %h", $time, name, exp, got);
    errors++;
  endtask

  // Compare DUT outputs against one due entry
  task automatic check_due(input byte kind, input logic [7:0] exp);
    checks++;
    case (kind)
      "R", "B": begin
        if (DATA_ENABLE !== 1'b1) begin
          report_value("DATA_ENABLE", 8'h01, {7'h00, DATA_ENABLE});
        end else if (DATA_OUT !== exp) begin
          report_value("DATA_OUT", exp, DATA_OUT);
        end
        last_out = exp;
      end
      "M": begin
        if (DATA_ENABLE !== 1'b0) begin
          report_value("DATA_ENABLE", 8'h00, {7'h00, DATA_ENABLE});
        end else if (DATA_OUT !== last_out) begin
          report_value("DATA_OUT", last_out, DATA_OUT);
        end
      end
      "D": begin
        if (PGM_DATA !== exp) begin
          report_value("PGM_DATA", exp, PGM_DATA);
        end
      end
      default: begin
        // Status bits 0, 1, 2
        if (ACTIVE !== exp[0]) begin
          report_value("ACTIVE", {7'h00, exp[0]}, {7'h00, ACTIVE});
        end
        if (RON !== exp[1]) begin
          report_value("RON", {7'h00, exp[1]}, {7'h00, RON});
        end
        if (RAN !== exp[2]) begin
          report_value("RAN", {7'h00, exp[2]}, {7'h00, RAN});
        end
      end
    endcase
  endtask

  // Let every pending check of the test land, then report it
  task automatic finish_test(input int t);
    while (due_q.size() != 0) begin
      @(negedge CLK);
    end
    ntests++;
    $display("Test %0d finished with %0d errors", t, errors - test_err);
  endtask

  // --------------------
  // Checker and timeout
  // --------------------
  // Outputs sampled mid-cycle, away from the rising edge
  always @(negedge CLK) begin
    cyc = cyc + 1;
    if (due_q.size() != 0 && due_q[0] == cyc) begin
      void'(due_q.pop_front());
      cur_kind = kind_q.pop_front();
      cur_exp  = exp_q.pop_front();
      check_due(cur_kind, cur_exp);
    end
    if (cyc > limit) begin
      $display("Timeout after %0d cycles, run did not complete", cyc);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int seed;
    int gap;
    int cur_test;
    RST      = 1'b1;
    ENABLE   = 1'b0;
    RD_START = 1'b0;
    WR_END   = 1'b0;
    ADDR     = 10'h000;
    DATA_IN  = 8'h00;
    PGM_ADDR = 10'h000;
    seed     = $urandom(32'h54c7f826);
    load_stim();
    limit = op_q.size() * CYCLES_PER_OP + 100;
    repeat (RST_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    cur_test = -1;
    foreach (op_q[i]) begin
      if (test_q[i] != cur_test) begin
        if (cur_test >= 0) begin
          finish_test(cur_test);
        end
        cur_test = test_q[i];
        test_err = errors;
      end
      // B follows the previous read on the very next cycle
      if (op_q[i] != "B") begin
        gap = $urandom % 4;
        repeat (gap) begin
          @(posedge CLK);
          drive_idle();
        end
      end
      // Status and debug reads wait for earlier writes to settle
      if (op_q[i] == "S" || op_q[i] == "D") begin
        repeat (3) begin
          @(posedge CLK);
          drive_idle();
        end
      end
      @(posedge CLK);
      drive_idle();
      case (op_q[i])
        "W": begin
          ENABLE  <= 1'b1;
          WR_END  <= 1'b1;
          ADDR    <= addr_q[i];
          DATA_IN <= data_q[i];
        end
        "R", "B", "M": begin
          ENABLE   <= 1'b1;
          RD_START <= 1'b1;
          ADDR     <= addr_q[i];
          // Registered next edge, data out in the cycle after the one following
          push_check(op_q[i], data_q[i], cyc + 3);
        end
        "D": begin
          PGM_ADDR <= addr_q[i];
          push_check("D", data_q[i], cyc + 2);
        end
        "S": push_check("S", data_q[i], cyc + 1);
        default: begin
          $display("Unknown opcode %c on stimulus line %0d", op_q[i], i + 1);
          errors++;
        end
      endcase
    end
    @(posedge CLK);
    drive_idle();
    if (cur_test >= 0) begin
      finish_test(cur_test);
    end
    $display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
    if (errors == 0 && ntests > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: design/gsu_top.sv
`timescale 1ns/1ps

module gsu_top #(
  parameter int CACHE_AW = gsu_pkg::CACHE_AW
) (
  input  logic       CLK,
  input  logic       RST,

  // Host MMIO
  input  logic       ENABLE,
  input  logic       RD_START,
  input  logic       WR_END,
  input  logic [9:0] ADDR,
  input  logic [7:0] DATA_IN,
  output logic       DATA_ENABLE,
  output logic [7:0] DATA_OUT,

  // Status
  output logic       ACTIVE,
  output logic       RON,
  output logic       RAN,

  // Debug cache read
  input  logic [9:0] PGM_ADDR,
  output logic [7:0] PGM_DATA
);

  gsu_reg_if reg_bus ();
  gsu_cache_if #(.CACHE_AW(CACHE_AW)) host_cache ();
  gsu_cache_if #(.CACHE_AW(CACHE_AW)) dbg_cache ();

  gsu_mmio_decode #(
    .CACHE_AW (CACHE_AW)
  ) mmio_decode_i (
    .CLK         (CLK),
    .RST         (RST),
    .enable      (ENABLE),
    .rd_start    (RD_START),
    .wr_end      (WR_END),
    .addr        (ADDR),
    .data_in     (DATA_IN),
    .data_enable (DATA_ENABLE),
    .data_out    (DATA_OUT),
    .regs        (reg_bus.decode),
    .cache       (host_cache.user)
  );

  // go/ron/ran drive ACTIVE/RON/RAN
  gsu_regfile regfile_i (
    .CLK  (CLK),
    .RST  (RST),
    .regs (reg_bus.regs),
    .go   (ACTIVE),
    .ron  (RON),
    .ran  (RAN)
  );

  gsu_cache_ram #(
    .CACHE_AW (CACHE_AW)
  ) cache_ram_i (
    .CLK  (CLK),
    .host (host_cache.ram),
    .dbg  (dbg_cache.ram)
  );

  // Debug port reads only, direct address
  assign dbg_cache.wren   = 1'b0;
  assign dbg_cache.addr   = CACHE_AW'(PGM_ADDR[8:0]);
  assign dbg_cache.wrdata = 8'h00;
  assign PGM_DATA         = dbg_cache.rddata;

endmodule

// File: design/gsu_cache_ram.sv
`timescale 1ns/1ps

module gsu_cache_ram #(
  parameter int CACHE_AW = gsu_pkg::CACHE_AW
) (
  input  logic     CLK,
  gsu_cache_if.ram host,
  gsu_cache_if.ram dbg
);

  localparam int DEPTH = 2 ** CACHE_AW;

  // Instruction bytes
  logic [7:0] mem [DEPTH];

  // --------------------
  // Both ports
  // --------------------
  // Read-before-write on each port
  always_ff @(posedge CLK) begin
    if (host.wren) begin
      mem[host.addr] <= host.wrdata;
    end
    if (dbg.wren) begin
      mem[dbg.addr] <= dbg.wrdata;
    end
    host.rddata <= mem[host.addr];
    dbg.rddata  <= mem[dbg.addr];
  end

endmodule

// File: design/gsu_regfile.sv
`timescale 1ns/1ps

module gsu_regfile (
  input  logic     CLK,
  input  logic     RST,
  gsu_reg_if.regs  regs,
  output logic     go,
  output logic     ron,
  output logic     ran
);

  // Writable bits per register
  localparam logic [7:0] SFR_L_MASK = 8'h7E;
  localparam logic [7:0] SFR_H_MASK = 8'h9F;
  localparam logic [7:0] SCMR_MASK  = 8'h3F;

  logic [15:0] gpr [gsu_pkg::NUM_GPR];
  // Low byte waits here for the high-byte write
  logic [7:0]  gpr_lo;
  logic [15:0] sfr;
  logic [7:0]  pbr;
  logic [7:0]  scmr;
  logic [7:0]  rd_byte;
  logic        rd_ok;

  // --------------------
  // Host writes
  // --------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int i = 0; i < gsu_pkg::NUM_GPR; i++) begin
        gpr[i] <= 16'h0000;
      end
      gpr_lo <= 8'h00;
      sfr    <= 16'h0000;
      pbr    <= 8'h00;
      scmr   <= 8'h00;
    end else if (regs.wr_en) begin
      case (regs.sel)
        gsu_pkg::SEL_GPR_L: gpr_lo <= regs.wdata;
        // Commit both bytes together
        gsu_pkg::SEL_GPR_H: gpr[regs.gpr_idx] <= {regs.wdata, gpr_lo};
        gsu_pkg::SEL_SFR_L: sfr[7:0] <= regs.wdata & SFR_L_MASK;
        gsu_pkg::SEL_SFR_H: sfr[15:8] <= regs.wdata & SFR_H_MASK;
        gsu_pkg::SEL_PBR:   pbr <= regs.wdata;
        gsu_pkg::SEL_SCMR:  scmr <= regs.wdata & SCMR_MASK;
        // Read-only and core-side registers keep nothing from the host
        default: ;
      endcase
    end
  end

  // --------------------
  // Read mux
  // --------------------
  // SCMR and the core-side registers miss on a host read
  always_comb begin
    rd_byte = 8'h00;
    rd_ok   = 1'b0;
    case (regs.sel)
      gsu_pkg::SEL_GPR_L: begin
        rd_ok   = 1'b1;
        rd_byte = gpr[regs.gpr_idx][7:0];
      end
      gsu_pkg::SEL_GPR_H: begin
        rd_ok   = 1'b1;
        rd_byte = gpr[regs.gpr_idx][15:8];
      end
      gsu_pkg::SEL_SFR_L: begin
        rd_ok   = 1'b1;
        rd_byte = sfr[7:0];
      end
      gsu_pkg::SEL_SFR_H: begin
        rd_ok   = 1'b1;
        rd_byte = sfr[15:8];
      end
      gsu_pkg::SEL_PBR: begin
        rd_ok   = 1'b1;
        rd_byte = pbr;
      end
      gsu_pkg::SEL_VCR: begin
        rd_ok   = 1'b1;
        rd_byte = gsu_pkg::VCR_RESET;
      end
      // Bank and cache base stay zero with no core
      gsu_pkg::SEL_ROMBR, gsu_pkg::SEL_RAMBR,
      gsu_pkg::SEL_CBR_L, gsu_pkg::SEL_CBR_H: begin
        rd_ok = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      regs.rd_hit <= 1'b0;
    end else begin
      regs.rd_hit <= regs.rd_en & rd_ok;
    end
  end

  always_ff @(posedge CLK) begin
    if (regs.rd_en) begin
      regs.rdata <= rd_byte;
    end
  end

  // Status breakouts
  assign go      = sfr[5];
  assign regs.go = sfr[5];
  assign ron     = scmr[4];
  assign ran     = scmr[3];

endmodule

// File: design/gsu_mmio_decode.sv
`timescale 1ns/1ps

module gsu_mmio_decode #(
  parameter int CACHE_AW = gsu_pkg::CACHE_AW
) (
  input  logic       CLK,
  input  logic       RST,
  input  logic       enable,
  input  logic       rd_start,
  input  logic       wr_end,
  input  logic [9:0] addr,
  input  logic [7:0] data_in,
  output logic       data_enable,
  output logic [7:0] data_out,
  gsu_reg_if.decode  regs,
  gsu_cache_if.user  cache
);

  logic              s1_rd;
  logic              s1_wr;
  logic [9:0]        s1_addr;
  logic [7:0]        s1_data;
  logic              page;
  logic              cache_ok;
  gsu_pkg::reg_sel_e sel_raw;
  gsu_pkg::reg_sel_e sel_ok;
  logic              s2_cache_rd;
  logic [7:0]        rd_byte;
  logic [7:0]        data_out_r;

  // Register page offset to select
  function automatic gsu_pkg::reg_sel_e decode_offset(input logic [7:0] ofs);
    gsu_pkg::reg_sel_e sel;
    sel = gsu_pkg::SEL_NONE;
    // General registers 00h-1Fh, odd offset is the high byte
    if (ofs[7:5] == 3'b000) begin
      sel = ofs[0] ? gsu_pkg::SEL_GPR_H : gsu_pkg::SEL_GPR_L;
    end else begin
      case (ofs)
        gsu_pkg::ADDR_SFR:         sel = gsu_pkg::SEL_SFR_L;
        gsu_pkg::ADDR_SFR + 8'd1:  sel = gsu_pkg::SEL_SFR_H;
        gsu_pkg::ADDR_BRAMR:       sel = gsu_pkg::SEL_BRAMR;
        gsu_pkg::ADDR_PBR:         sel = gsu_pkg::SEL_PBR;
        gsu_pkg::ADDR_ROMBR:       sel = gsu_pkg::SEL_ROMBR;
        gsu_pkg::ADDR_CFGR:        sel = gsu_pkg::SEL_CFGR;
        gsu_pkg::ADDR_SCBR:        sel = gsu_pkg::SEL_SCBR;
        gsu_pkg::ADDR_CLSR:        sel = gsu_pkg::SEL_CLSR;
        gsu_pkg::ADDR_SCMR:        sel = gsu_pkg::SEL_SCMR;
        gsu_pkg::ADDR_VCR:         sel = gsu_pkg::SEL_VCR;
        gsu_pkg::ADDR_RAMBR:       sel = gsu_pkg::SEL_RAMBR;
        gsu_pkg::ADDR_CBR:         sel = gsu_pkg::SEL_CBR_L;
        gsu_pkg::ADDR_CBR + 8'd1:  sel = gsu_pkg::SEL_CBR_H;
        default:                   sel = gsu_pkg::SEL_NONE;
      endcase
    end
    return sel;
  endfunction

  // --------------------
  // Stage 1
  // --------------------
  // Read wins if both strobes arrive together
  always_ff @(posedge CLK) begin
    if (RST) begin
      s1_rd <= 1'b0;
      s1_wr <= 1'b0;
    end else begin
      s1_rd <= enable & rd_start;
      s1_wr <= enable & wr_end & ~rd_start;
    end
  end

  always_ff @(posedge CLK) begin
    s1_addr <= addr;
    s1_data <= data_in;
  end

  // --------------------
  // Stage 2
  // --------------------
  assign page    = (s1_addr[9:8] == 2'b00);
  assign sel_raw = page ? decode_offset(s1_addr[7:0]) : gsu_pkg::SEL_NONE;

  // GO lockout
  // Only SFR/SCMR writes and SFR/VCR reads pass while running
  always_comb begin
    sel_ok = sel_raw;
    if (regs.go) begin
      if (s1_wr && !(sel_raw inside {gsu_pkg::SEL_SFR_L, gsu_pkg::SEL_SFR_H,
                                     gsu_pkg::SEL_SCMR})) begin
        sel_ok = gsu_pkg::SEL_NONE;
      end
      if (s1_rd && !(sel_raw inside {gsu_pkg::SEL_SFR_L, gsu_pkg::SEL_SFR_H,
                                     gsu_pkg::SEL_VCR})) begin
        sel_ok = gsu_pkg::SEL_NONE;
      end
    end
  end

  // Cache closed to the host while GO is set
  assign cache_ok = ~page & ~regs.go;

  assign regs.wr_en   = s1_wr & page;
  assign regs.rd_en   = s1_rd & page;
  assign regs.sel     = sel_ok;
  assign regs.gpr_idx = s1_addr[4:1];
  assign regs.wdata   = s1_data;

  // Bit 8 inverted into the cache
  assign cache.wren   = s1_wr & cache_ok;
  assign cache.addr   = CACHE_AW'({~s1_addr[8], s1_addr[7:0]});
  assign cache.wrdata = s1_data;

  // Tag for the read return
  always_ff @(posedge CLK) begin
    if (RST) begin
      s2_cache_rd <= 1'b0;
    end else begin
      s2_cache_rd <= s1_rd & cache_ok;
    end
  end

  // --------------------
  // Read return
  // --------------------
  // Every cache read returns data, register reads only on a hit
  assign data_enable = s2_cache_rd | regs.rd_hit;
  assign rd_byte     = s2_cache_rd ? cache.rddata : regs.rdata;

  // Hold the last byte across misses and idle cycles
  always_ff @(posedge CLK) begin
    if (RST) begin
      data_out_r <= 8'h00;
    end else if (data_enable) begin
      data_out_r <= rd_byte;
    end
  end

  assign data_out = data_enable ? rd_byte : data_out_r;

endmodule

// File: design/gsu_cache_if.sv
`timescale 1ns/1ps

interface gsu_cache_if #(
  parameter int CACHE_AW = gsu_pkg::CACHE_AW
);

  logic                wren;
  logic [CACHE_AW-1:0] addr;
  logic [7:0]          wrdata;
  // Valid one cycle after addr
  logic [7:0]          rddata;

  modport user (output wren, addr, wrdata, input rddata);

  modport ram (input wren, addr, wrdata, output rddata);

endinterface

// File: design/gsu_reg_if.sv
`timescale 1ns/1ps

interface gsu_reg_if;

  // Decoded byte access, one pulse per access
  logic                wr_en;
  logic                rd_en;
  gsu_pkg::reg_sel_e   sel;
  logic [3:0]          gpr_idx;
  logic [7:0]          wdata;

  // Read return, one cycle after rd_en
  logic [7:0]          rdata;
  logic                rd_hit;
  // SFR GO for the lockout
  logic                go;

  modport decode (
    output wr_en, rd_en, sel, gpr_idx, wdata,
    input  rdata, rd_hit, go
  );

  modport regs (
    input  wr_en, rd_en, sel, gpr_idx, wdata,
    output rdata, rd_hit, go
  );

endinterface

// File: design/gsu_pkg.sv
package gsu_pkg;

  // --------------------
  // Register page offsets
  // --------------------
  // Low byte of each 16-bit register, high byte at offset + 1
  localparam logic [7:0] ADDR_SFR   = 8'h30;
  localparam logic [7:0] ADDR_BRAMR = 8'h33;
  localparam logic [7:0] ADDR_PBR   = 8'h34;
  localparam logic [7:0] ADDR_ROMBR = 8'h36;
  localparam logic [7:0] ADDR_CFGR  = 8'h37;
  localparam logic [7:0] ADDR_SCBR  = 8'h38;
  localparam logic [7:0] ADDR_CLSR  = 8'h39;
  localparam logic [7:0] ADDR_SCMR  = 8'h3A;
  localparam logic [7:0] ADDR_VCR   = 8'h3B;
  localparam logic [7:0] ADDR_RAMBR = 8'h3C;
  localparam logic [7:0] ADDR_CBR   = 8'h3E;

  // --------------------
  // Reset values and sizes
  // --------------------
  // Version code returned by VCR
  localparam logic [7:0] VCR_RESET = 8'h04;
  localparam int NUM_GPR = 16;
  // 512-byte instruction cache
  localparam int CACHE_AW = 9;

  // Decoded target of one MMIO byte access
  typedef enum logic [7:0] {
    SEL_NONE,
    SEL_GPR_L,
    SEL_GPR_H,
    SEL_SFR_L,
    SEL_SFR_H,
    SEL_BRAMR,
    SEL_PBR,
    SEL_ROMBR,
    SEL_CFGR,
    SEL_SCBR,
    SEL_CLSR,
    SEL_SCMR,
    SEL_VCR,
    SEL_RAMBR,
    SEL_CBR_L,
    SEL_CBR_H
  } reg_sel_e;

endpackage
